//--- filelist.f
+incdir+testbench
hdl/btc_pkg.sv
hdl/block_builder.sv
hdl/sha256_core.sv
hdl/mem_sequencer.sv
hdl/hash_control.sv
hdl/bitcoin_hash.sv
testbench/tb_bitcoin_hash.sv

//--- hdl/bitcoin_hash.sv
`timescale 1ns/10ps

module bitcoin_hash (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           start,
    input  btc_pkg::addr_t message_addr,
    input  btc_pkg::addr_t output_addr,
    input  btc_pkg::word_t mem_read_data,
    output logic           done,
    output logic           mem_we,
    output btc_pkg::addr_t mem_addr,
    output btc_pkg::word_t mem_write_data
);

    btc_pkg::mem_req_t                          mem_req;
    logic                                       fetch_start;
    logic                                       fetch_done;
    btc_pkg::word_t [0:btc_pkg::HEADER_WORDS-1] header_words;
    logic                                       use_header_tail;
    btc_pkg::word_t                             nonce;
    logic                                       core_start;
    logic                                       core_done;
    btc_pkg::block_t                            core_block;
    btc_pkg::digest_t                           core_chain;
    btc_pkg::digest_t                           digest_out;
    btc_pkg::block_t                            built_block;
    logic                                       result_valid;
    btc_pkg::word_t                             result_word;
    logic [btc_pkg::IDX_W-1:0]                  result_index;

    assign mem_we         = mem_req.we;
    assign mem_addr       = mem_req.addr;
    assign mem_write_data = mem_req.wdata;

    hash_control ctrl0 (
        .clk             (clk),
        .reset_n         (reset_n),
        .start           (start),
        .fetch_done      (fetch_done),
        .header_words    (header_words),
        .core_done       (core_done),
        .digest_out      (digest_out),
        .built_block     (built_block),
        .fetch_start     (fetch_start),
        .use_header_tail (use_header_tail),
        .nonce           (nonce),
        .core_start      (core_start),
        .core_block      (core_block),
        .core_chain      (core_chain),
        .result_valid    (result_valid),
        .result_word     (result_word),
        .result_index    (result_index),
        .done            (done)
    );

    mem_sequencer mseq0 (
        .clk           (clk),
        .reset_n       (reset_n),
        .fetch_start   (fetch_start),
        .message_addr  (message_addr),
        .output_addr   (output_addr),
        .mem_read_data (mem_read_data),
        .result_valid  (result_valid),
        .result_word   (result_word),
        .result_index  (result_index),
        .mem_req       (mem_req),
        .fetch_done    (fetch_done),
        .header_words  (header_words)
    );

    sha256_core core0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (core_start),
        .block      (core_block),
        .chain_in   (core_chain),
        .done       (core_done),
        .digest_out (digest_out)
    );

    block_builder bld0 (
        .use_header_tail (use_header_tail),
        .header_tail     (header_words[16:18]),
        .nonce           (nonce),
        .digest_in       (digest_out),
        .block           (built_block)
    );

endmodule

//--- hdl/block_builder.sv
`timescale 1ns/10ps

module block_builder (
    input  logic                 use_header_tail,
    input  btc_pkg::word_t [0:2] header_tail,
    input  btc_pkg::word_t       nonce,
    input  btc_pkg::digest_t     digest_in,
    output btc_pkg::block_t      block
);

    always_comb begin
        block = '0;
        if (use_header_tail) begin
            // Second block of the 640-bit header message
            block[0:2] = header_tail;
            block[3]   = nonce;
            block[4]   = btc_pkg::PAD_WORD;
            block[15]  = btc_pkg::LEN_HEADER;
        end else begin
            // Single block over the first digest
            block[0:7] = digest_in;
            block[8]   = btc_pkg::PAD_WORD;
            block[15]  = btc_pkg::LEN_DIGEST;
        end
    end

endmodule

//--- hdl/btc_pkg.sv
package btc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [15:0] addr_t;

    typedef word_t [0:7]  digest_t;    // H0 first
    typedef word_t [0:15] block_t;     // Word 0 first

    localparam int HEADER_WORDS = 20;
    localparam int NUM_NONCES   = 16;
    localparam int NUM_ROUNDS   = 64;

    localparam int IDX_W   = $clog2(NUM_NONCES);
    localparam int ROUND_W = $clog2(NUM_ROUNDS);

    localparam word_t PAD_WORD   = 32'h8000_0000;
    localparam word_t LEN_HEADER = 32'd640;    // 20 words of header
    localparam word_t LEN_DIGEST = 32'd256;    // One digest

    localparam digest_t SHA256_IV = {
        32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
        32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
    };

    localparam word_t [0:NUM_ROUNDS-1] SHA256_K = {
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    typedef enum logic [2:0] {
        IDLE,
        READ,
        MIDSTATE,
        SECOND,
        THIRD,
        WRITE
    } phase_e;

    typedef struct packed {
        logic  we;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

endpackage

//--- hdl/hash_control.sv
`timescale 1ns/10ps

module hash_control (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  logic                                   start,
    input  logic                                   fetch_done,
    input  btc_pkg::word_t [0:btc_pkg::HEADER_WORDS-1] header_words,
    input  logic                                   core_done,
    input  btc_pkg::digest_t                       digest_out,
    input  btc_pkg::block_t                        built_block,
    output logic                                   fetch_start,
    output logic                                   use_header_tail,
    output btc_pkg::word_t                         nonce,
    output logic                                   core_start,
    output btc_pkg::block_t                        core_block,
    output btc_pkg::digest_t                       core_chain,
    output logic                                   result_valid,
    output btc_pkg::word_t                         result_word,
    output logic [btc_pkg::IDX_W-1:0]              result_index,
    output logic                                   done
);

    btc_pkg::phase_e             phase;
    logic [btc_pkg::IDX_W-1:0]   nonce_idx;
    btc_pkg::digest_t            midstate;
    logic                        core_busy;

    assign use_header_tail = (phase == btc_pkg::SECOND);
    assign nonce           = btc_pkg::word_t'(nonce_idx);

    // Core samples block and chain while core_start is high
    always_comb begin
        core_block = built_block;
        core_chain = btc_pkg::SHA256_IV;
        if (phase == btc_pkg::MIDSTATE) begin
            core_block = header_words[0:15];
        end else if (phase == btc_pkg::SECOND) begin
            core_chain = midstate;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            phase        <= btc_pkg::IDLE;
            fetch_start  <= 1'b0;
            core_start   <= 1'b0;
            result_valid <= 1'b0;
            done         <= 1'b0;
            nonce_idx    <= '0;
            core_busy    <= 1'b0;
        end else begin
            fetch_start  <= 1'b0;
            core_start   <= 1'b0;
            result_valid <= 1'b0;
            done         <= 1'b0;

            if (core_start) begin
                core_busy <= 1'b1;
            end else if (core_done) begin
                core_busy <= 1'b0;
            end

            case (phase)
                btc_pkg::IDLE: begin
                    if (start) begin
                        fetch_start <= 1'b1;
                        nonce_idx   <= '0;
                        phase       <= btc_pkg::READ;
                    end
                end
                btc_pkg::READ: begin
                    if (fetch_done) begin
                        core_start <= 1'b1;
                        phase      <= btc_pkg::MIDSTATE;
                    end
                end
                btc_pkg::MIDSTATE: begin
                    if (core_done) begin
                        core_start <= 1'b1;
                        phase      <= btc_pkg::SECOND;
                    end
                end
                btc_pkg::SECOND: begin
                    if (core_done) begin
                        core_start <= 1'b1;    // Digest stays on the core output
                        phase      <= btc_pkg::THIRD;
                    end
                end
                btc_pkg::THIRD: begin
                    if (core_done) begin
                        result_valid <= 1'b1;
                        phase        <= btc_pkg::WRITE;
                    end
                end
                btc_pkg::WRITE: begin
                    if (&nonce_idx) begin    // Last nonce written
                        done  <= 1'b1;
                        phase <= btc_pkg::IDLE;
                    end else begin
                        nonce_idx  <= nonce_idx + 1'b1;
                        core_start <= 1'b1;
                        phase      <= btc_pkg::SECOND;
                    end
                end
                default: phase <= btc_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == btc_pkg::MIDSTATE && core_done) begin
            midstate <= digest_out;
        end
        if (phase == btc_pkg::THIRD && core_done) begin
            result_word  <= digest_out[0];    // H0
            result_index <= nonce_idx;
        end
    end

    a_core_not_busy: assert property (
        @(posedge clk) disable iff (!reset_n) core_busy |-> !core_start
    ) else $error("core started while busy");

endmodule

//--- hdl/mem_sequencer.sv
`timescale 1ns/10ps

module mem_sequencer (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  logic                                   fetch_start,
    input  btc_pkg::addr_t                         message_addr,
    input  btc_pkg::addr_t                         output_addr,
    input  btc_pkg::word_t                         mem_read_data,
    input  logic                                   result_valid,
    input  btc_pkg::word_t                         result_word,
    input  logic [btc_pkg::IDX_W-1:0]              result_index,
    output btc_pkg::mem_req_t                      mem_req,
    output logic                                   fetch_done,
    output btc_pkg::word_t [0:btc_pkg::HEADER_WORDS-1] header_words
);

    logic       reading;
    logic [4:0] cnt;    // Cycles since fetch_start, 0 to HEADER_WORDS

    // Last header word is on the read bus in this cycle
    assign fetch_done = reading && (cnt == 5'(btc_pkg::HEADER_WORDS));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            reading <= 1'b0;
            cnt     <= '0;
            mem_req <= '0;
        end else begin
            mem_req.we <= 1'b0;
            if (fetch_start) begin
                reading      <= 1'b1;
                cnt          <= '0;
                mem_req.addr <= message_addr;
            end else if (reading) begin
                cnt <= cnt + 1'b1;
                if (cnt < 5'(btc_pkg::HEADER_WORDS - 1)) begin
                    mem_req.addr <= mem_req.addr + 1'b1;
                end
                if (fetch_done) begin
                    reading <= 1'b0;
                end
            end

            if (result_valid) begin
                mem_req.we    <= 1'b1;
                mem_req.addr  <= output_addr + btc_pkg::addr_t'(result_index);
                mem_req.wdata <= result_word;
            end
        end
    end

    // Read data trails its address by one cycle
    always_ff @(posedge clk) begin
        if (reading && cnt != '0) begin
            header_words[cnt - 1'b1] <= mem_read_data;
        end
    end

    a_no_write_in_fetch: assert property (
        @(posedge clk) disable iff (!reset_n) reading |-> !mem_req.we
    ) else $error("write issued during header read");

endmodule

//--- hdl/sha256_core.sv
`timescale 1ns/10ps

module sha256_core (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             start,
    input  btc_pkg::block_t  block,
    input  btc_pkg::digest_t chain_in,
    output logic             done,
    output btc_pkg::digest_t digest_out
);

    logic                        busy;
    logic [btc_pkg::ROUND_W-1:0] round;
    btc_pkg::digest_t            chain_q;
    btc_pkg::digest_t            work;     // a to h
    btc_pkg::block_t             sched;    // W[t] sits in word 0

    btc_pkg::word_t a, b, c, d, e, f, g, h;
    btc_pkg::word_t t1, t2, w_next;

    function automatic btc_pkg::word_t rotr(btc_pkg::word_t x, int n);
        return (x >> n) | (x << (32 - n));
    endfunction

    function automatic btc_pkg::word_t big_sigma0(btc_pkg::word_t x);
        return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
    endfunction

    function automatic btc_pkg::word_t big_sigma1(btc_pkg::word_t x);
        return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
    endfunction

    function automatic btc_pkg::word_t small_sigma0(btc_pkg::word_t x);
        return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
    endfunction

    function automatic btc_pkg::word_t small_sigma1(btc_pkg::word_t x);
        return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
    endfunction

    always_comb begin
        {a, b, c, d, e, f, g, h} = work;
        t1 = h + big_sigma1(e) + ((e & f) ^ (~e & g)) + btc_pkg::SHA256_K[round] + sched[0];
        t2 = big_sigma0(a) + ((a & b) ^ (a & c) ^ (b & c));
        // W[t+16] enters at the tail of the window
        w_next = small_sigma1(sched[14]) + sched[9] + small_sigma0(sched[1]) + sched[0];
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy  <= 1'b0;
            round <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                round <= '0;
            end else if (busy) begin
                round <= round + 1'b1;
                if (&round) begin    // Last round
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            chain_q <= chain_in;
            work    <= chain_in;
            sched   <= block;
        end else if (busy) begin
            work  <= {t1 + t2, a, b, c, d + t1, e, f, g};
            sched <= {sched[1:15], w_next};
        end
    end

    // Feed-forward add, held until the next start
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            digest_out[i] = chain_q[i] + work[i];
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f filelist.f \
        --top-module tb_bitcoin_hash -o sim_tb; then
    echo "Verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1

//--- testbench/sha256_model.svh
`ifndef SHA256_MODEL_SVH
`define SHA256_MODEL_SVH

function automatic btc_pkg::word_t ror32(btc_pkg::word_t x, int n);
    return btc_pkg::word_t'({x, x} >> n);
endfunction

// One SHA-256 compression with the full 64-word schedule
function automatic btc_pkg::digest_t compress(btc_pkg::digest_t chain, btc_pkg::block_t blk);
    btc_pkg::word_t w [0:63];
    btc_pkg::word_t a, b, c, d, e, f, g, h;
    btc_pkg::word_t s0, s1, t1, t2;
    for (int t = 0; t < 16; t++) begin
        w[6'(t)] = blk[4'(t)];
    end
    for (int t = 16; t < 64; t++) begin
        s0 = ror32(w[6'(t - 15)], 7) ^ ror32(w[6'(t - 15)], 18) ^ (w[6'(t - 15)] >> 3);
        s1 = ror32(w[6'(t - 2)], 17) ^ ror32(w[6'(t - 2)], 19) ^ (w[6'(t - 2)] >> 10);
        w[6'(t)] = w[6'(t - 16)] + s0 + w[6'(t - 7)] + s1;
    end
    {a, b, c, d, e, f, g, h} = chain;
    for (int t = 0; t < 64; t++) begin
        s1 = ror32(e, 6) ^ ror32(e, 11) ^ ror32(e, 25);
        t1 = h + s1 + ((e & f) ^ (~e & g)) + btc_pkg::SHA256_K[6'(t)] + w[6'(t)];
        s0 = ror32(a, 2) ^ ror32(a, 13) ^ ror32(a, 22);
        t2 = s0 + ((a & b) ^ (a & c) ^ (b & c));
        h = g;
        g = f;
        f = e;
        e = d + t1;
        d = c;
        c = b;
        b = a;
        a = t1 + t2;
    end
    return {chain[0] + a, chain[1] + b, chain[2] + c, chain[3] + d,
            chain[4] + e, chain[5] + f, chain[6] + g, chain[7] + h};
endfunction

// H0 of the double hash for one nonce
function automatic btc_pkg::word_t expected_h0(
    btc_pkg::word_t [0:btc_pkg::HEADER_WORDS-1] hdr,
    btc_pkg::word_t nonce
);
    btc_pkg::digest_t mid, d1, d2;
    btc_pkg::block_t  blk;
    mid = compress(btc_pkg::SHA256_IV, hdr[0:15]);
    blk = '0;
    blk[0:2] = hdr[16:18];
    blk[3]   = nonce;
    blk[4]   = 32'h8000_0000;
    blk[15]  = 32'd640;    // 80-byte header
    d1 = compress(mid, blk);
    blk = '0;
    blk[0:7] = d1;
    blk[8]   = 32'h8000_0000;
    blk[15]  = 32'd256;
    d2 = compress(btc_pkg::SHA256_IV, blk);
    return d2[0];
endfunction

`endif

//--- testbench/tb_bitcoin_hash.sv
`timescale 1ns/10ps

module tb_bitcoin_hash;

    localparam int NUM_TESTS       = 4;
    localparam int RUN_LIMIT       = 40 * 70;    // Cycles allowed per test
    localparam int WATCHDOG_CYCLES = NUM_TESTS * RUN_LIMIT + 200;

    typedef btc_pkg::word_t [0:btc_pkg::HEADER_WORDS-1] header_t;

    logic           clk;
    logic           reset_n;
    logic           start;
    btc_pkg::addr_t message_addr;
    btc_pkg::addr_t output_addr;
    btc_pkg::word_t mem_read_data;
    logic           done;
    logic           mem_we;
    btc_pkg::addr_t mem_addr;
    btc_pkg::word_t mem_write_data;

    btc_pkg::word_t mem [0:65535];
    btc_pkg::word_t ref_mem [0:65535];    // Expected memory image
    int errors;
    int tests_run;
    int write_count;
    int done_count;

    `include "sha256_model.svh"

    bitcoin_hash dut0 (
        .clk            (clk),
        .reset_n        (reset_n),
        .start          (start),
        .message_addr   (message_addr),
        .output_addr    (output_addr),
        .mem_read_data  (mem_read_data),
        .done           (done),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_write_data (mem_write_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Synchronous RAM with one cycle of read latency
    always @(posedge clk) begin
        mem_read_data <= mem[mem_addr];    // Read before write
        if (mem_we) begin
            mem[mem_addr] = mem_write_data;
        end
    end

    always @(negedge clk) begin
        if (mem_we) write_count++;
        if (done) done_count++;
    end

    task automatic fill_memory();
        for (int a = 0; a < 65536; a++) begin
            mem[a[15:0]]     = {a[15:0] ^ 16'hc3a5, a[15:0]};
            ref_mem[a[15:0]] = {a[15:0] ^ 16'hc3a5, a[15:0]};
        end
    endtask

    task automatic check_memory(input string name);
        int shown;
        shown = 0;
        for (int a = 0; a < 65536; a++) begin
            if (mem[a[15:0]] !== ref_mem[a[15:0]]) begin
                errors++;
                if (shown < 10) begin
                    $display("ERR %s: mem[%h] expected %h, actual %h", name, a[15:0],
                             ref_mem[a[15:0]], mem[a[15:0]]);
                end
                shown++;
            end
        end
    endtask

    // One full run with an optional stray start pulse mid-run
    task automatic run_hash(input string name, input btc_pkg::addr_t msg,
                            input btc_pkg::addr_t out, input header_t hdr,
                            input bit stray_start);
        int writes0, dones0, cycles;
        for (int i = 0; i < btc_pkg::HEADER_WORDS; i++) begin
            mem[msg + 16'(i)]     = hdr[5'(i)];
            ref_mem[msg + 16'(i)] = hdr[5'(i)];
        end
        for (int n = 0; n < btc_pkg::NUM_NONCES; n++) begin
            ref_mem[out + 16'(n)] = expected_h0(hdr, 32'(n));
        end
        writes0 = write_count;
        dones0  = done_count;
        @(negedge clk);
        message_addr = msg;
        output_addr  = out;
        start        = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (stray_start) begin
            repeat (100) @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        cycles = 0;
        while (!done && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("%s: done did not arrive within %0d cycles", name, RUN_LIMIT);
            errors++;
        end
        repeat (4) @(negedge clk);    // Catch late writes or a second done
        if (write_count - writes0 != btc_pkg::NUM_NONCES) begin
            $display("ERR %s: write count expected %0d, actual %0d", name,
                     btc_pkg::NUM_NONCES, write_count - writes0);
            errors++;
        end
        if (done_count - dones0 != 1) begin
            $display("ERR %s: done pulses expected 1, actual %0d", name, done_count - dones0);
            errors++;
        end
        check_memory(name);
    endtask

    task automatic idle_after_reset();
        tests_run++;
        repeat (8) begin
            @(negedge clk);
            if (done !== 1'b0 || mem_we !== 1'b0) begin
                $display("idle_after_reset: done or mem_we went high without start");
                errors++;
            end
        end
    endtask

    task automatic fixed_header();
        header_t hdr;
        tests_run++;
        for (int i = 0; i < btc_pkg::HEADER_WORDS; i++) begin
            hdr[5'(i)] = {8'(4 * i), 8'(4 * i + 1), 8'(4 * i + 2), 8'(4 * i + 3)};
        end
        run_hash("fixed_header", 16'h0000, 16'h0100, hdr, 1'b0);
    endtask

    task automatic random_header();
        header_t        hdr;
        btc_pkg::addr_t msg;
        tests_run++;
        for (int i = 0; i < btc_pkg::HEADER_WORDS; i++) begin
            hdr[5'(i)] = $urandom;
        end
        msg = 16'($urandom_range(32'h7f00, 32'h0200));
        run_hash("random_header", msg, msg + 16'h0100 + 16'($urandom_range(255, 0)), hdr, 1'b0);
    endtask

    task automatic back_to_back();
        header_t hdr;
        tests_run++;
        for (int i = 0; i < btc_pkg::HEADER_WORDS; i++) begin
            hdr[5'(i)] = $urandom;
        end
        run_hash("back_to_back_a", 16'h9000, 16'ha000, hdr, 1'b1);
        run_hash("back_to_back_b", 16'hb000, 16'hc000, ~hdr, 1'b0);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h4442a080));
        errors        = 0;
        tests_run     = 0;
        write_count   = 0;
        done_count    = 0;
        reset_n       = 1'b0;
        start         = 1'b0;
        message_addr  = '0;
        output_addr   = '0;
        mem_read_data <= '0;
        fill_memory();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        idle_after_reset();
        fixed_header();
        random_header();
        back_to_back();
        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
